// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sobelAcceleratorTb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= SOME TESTS FAILED
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
rtl/sobelPkg.sv
rtl/configRegisters.sv
rtl/sobelWindow.sv
rtl/edgeWordFifo.sv
rtl/burstWriter.sv
rtl/sobelAccelerator.sv
tests/cameraClock.sv
tests/busSlaveModel.sv
tests/sobelAcceleratorTb.sv

// ==== rtl/burstWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstWriter (
    input wire camClock,
    input wire reset,
    input wire sobelPkg::wordT busStart,
    input wire frameStart,
    input wire sobelPkg::fifoCountT wordCount,
    input wire sobelPkg::wordT readData,
    input wire busGrant,
    input wire busyIn,
    output logic readStrobe,
    output logic requestBus,
    output logic beginTransactionOut,
    output sobelPkg::wordT addressDataOut,
    output logic endTransactionOut,
    output logic [3:0] byteEnablesOut,
    output logic dataValidOut,
    output logic [7:0] burstSizeOut
);
    import sobelPkg::*;

    writerStateT state;
    writerStateT nextState;
    // Words of the current burst already put on the bus
    burstCountT loadedWords;
    wordT busAddress;
    logic burstLoaded;
    logic loadWord;
    logic lastAccept;
    logic issueBegin;

    assign burstLoaded = loadedWords == burstCountT'(maxBurst);
    // Next word goes out only when the bus is not stalling
    assign loadWord = (state == write) && !burstLoaded && !busyIn;
    assign lastAccept = (state == write) && burstLoaded && dataValidOut && !busyIn;
    // Begin is issued on the second init cycle
    assign issueBegin = (state == init) && !beginTransactionOut;

    // Pop as the word moves onto the bus
    assign readStrobe = loadWord;
    assign requestBus = state == request;

    always_comb begin
        case (state)
            idle: nextState = (wordCount >= fifoCountT'(maxBurst)) ? request : idle;
            request: nextState = busGrant ? init : request;
            init: nextState = beginTransactionOut ? write : init;
            write: nextState = lastAccept ? close : write;
            close: nextState = idle;
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge camClock) begin
        if (reset) begin
            state <= idle;
            beginTransactionOut <= 1'b0;
            endTransactionOut <= 1'b0;
            byteEnablesOut <= '0;
            burstSizeOut <= '0;
            loadedWords <= '0;
        end else begin
            state <= nextState;
            beginTransactionOut <= issueBegin;
            // End follows the accepted last word by one cycle
            endTransactionOut <= lastAccept;
            byteEnablesOut <= issueBegin ? 4'hf : 4'h0;
            burstSizeOut <= issueBegin ? 8'(maxBurst - 1) : 8'd0;
            if (state == init) begin
                loadedWords <= '0;
            end else if (loadWord) begin
                loadedWords <= loadedWords + 1'b1;
            end
        end
    end

    // Shared address/data lines, held while busy
    always_ff @(posedge camClock) begin
        if (reset) begin
            addressDataOut <= '0;
            dataValidOut <= 1'b0;
        end else begin
            if (issueBegin) begin
                addressDataOut <= busAddress;
            end else if (loadWord) begin
                addressDataOut <= readData;
            end else if (!busyIn) begin
                addressDataOut <= '0;
            end
            if (loadWord) begin
                dataValidOut <= 1'b1;
            end else if (!busyIn) begin
                dataValidOut <= 1'b0;
            end
        end
    end

    // Address reloads per frame, steps per accepted word
    always_ff @(posedge camClock) begin
        if (reset) begin
            busAddress <= '0;
        end else if (frameStart) begin
            busAddress <= busStart;
        end else if (dataValidOut && !busyIn) begin
            busAddress <= busAddress + wordT'(addressStep);
        end
    end

    assert property (@(posedge camClock) disable iff (reset)
        (state == write) |-> !beginTransactionOut);

endmodule

`default_nettype wire

// ==== rtl/configRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module configRegisters (
    input wire camClock,
    input wire reset,
    input wire ciStart,
    input wire [7:0] ciN,
    input wire sobelPkg::wordT ciValueA,
    input wire sobelPkg::wordT ciValueB,
    input wire vsync,
    output sobelPkg::wordT ciResult,
    output logic ciDone,
    output sobelPkg::wordT busStart,
    output sobelPkg::magnitudeT threshold,
    output logic frameActive,
    output logic frameStart
);
    import sobelPkg::*;

    logic validInstr;
    logic isWrite;
    regSelectT select;
    logic startCommand;
    logic armed;
    logic statusDone;
    logic vsyncLast;

    // Instruction is ours only for our custom number
    assign validInstr = ciStart && (ciN == customId);
    assign ciDone = validInstr;
    assign select = ciValueA[12:10];
    assign isWrite = ciValueA[writeBit];
    // Writing the status register is the start command
    assign startCommand = validInstr && isWrite && (select == regStatus);
    // Rising edge of vsync, one cycle wide
    assign frameStart = vsync && !vsyncLast;

    // Readback mux, zero on writes and unknown selects
    always_comb begin
        ciResult = '0;
        if (validInstr && !isWrite) begin
            case (select)
                regBusStart: ciResult = busStart;
                regThreshold: ciResult = wordT'(threshold);
                regStatus: ciResult = wordT'({statusDone, armed | frameActive});
                default: ciResult = '0;
            endcase
        end
    end

    always_ff @(posedge camClock) begin
        if (reset) begin
            busStart <= '0;
            threshold <= '0;
        end else if (validInstr && isWrite) begin
            if (select == regBusStart) begin
                busStart <= ciValueB;
            end
            if (select == regThreshold) begin
                threshold <= ciValueB[15:0];
            end
        end
    end

    // One-shot transfer, armed until the frame goes active
    always_ff @(posedge camClock) begin
        if (reset || frameActive) begin
            armed <= 1'b0;
        end else if (startCommand) begin
            armed <= 1'b1;
        end
    end

    // Status shifts on each frame boundary
    always_ff @(posedge camClock) begin
        if (reset || startCommand) begin
            frameActive <= 1'b0;
            statusDone <= 1'b0;
        end else if (frameStart) begin
            frameActive <= armed;
            statusDone <= frameActive;
        end
    end

    always_ff @(posedge camClock) begin
        if (reset) begin
            vsyncLast <= 1'b0;
        end else begin
            vsyncLast <= vsync;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/edgeWordFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module edgeWordFifo (
    input wire camClock,
    input wire reset,
    input wire writeStrobe,
    input wire sobelPkg::wordT writeData,
    input wire readStrobe,
    output sobelPkg::wordT readData,
    output sobelPkg::fifoCountT wordCount
);
    import sobelPkg::*;

    wordT storage [fifoDepth];
    logic [$clog2(fifoDepth)-1:0] writePointer;
    logic [$clog2(fifoDepth)-1:0] readPointer;

    // Oldest word always visible
    assign readData = storage[readPointer];

    always_ff @(posedge camClock) begin
        if (writeStrobe) begin
            storage[writePointer] <= writeData;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge camClock) begin
        if (reset) begin
            writePointer <= '0;
            readPointer <= '0;
        end else begin
            if (writeStrobe) begin
                writePointer <= writePointer + 1'b1;
            end
            if (readStrobe) begin
                readPointer <= readPointer + 1'b1;
            end
        end
    end

    always_ff @(posedge camClock) begin
        if (reset) begin
            wordCount <= '0;
        end else begin
            case ({writeStrobe, readStrobe})
                2'b10: wordCount <= wordCount + 1'b1;
                2'b01: wordCount <= wordCount - 1'b1;
                default: wordCount <= wordCount;
            endcase
        end
    end

    // Producer has no back-pressure, bus must keep up
    assert property (@(posedge camClock) disable iff (reset)
        writeStrobe |-> (wordCount != fifoCountT'(fifoDepth)));
    assert property (@(posedge camClock) disable iff (reset)
        readStrobe |-> (wordCount != '0));

endmodule

`default_nettype wire

// ==== rtl/sobelAccelerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelAccelerator (
    input wire camClock,
    input wire reset,
    input wire hsync,
    input wire vsync,
    input wire validCamera,
    input wire sobelPkg::pixelT camData,
    input wire ciStart,
    input wire [7:0] ciN,
    input wire sobelPkg::wordT ciValueA,
    input wire sobelPkg::wordT ciValueB,
    output sobelPkg::wordT ciResult,
    output logic ciDone,
    output logic requestBus,
    input wire busGrant,
    output logic beginTransactionOut,
    output sobelPkg::wordT addressDataOut,
    output logic endTransactionOut,
    output logic [3:0] byteEnablesOut,
    output logic dataValidOut,
    output logic [7:0] burstSizeOut,
    input wire busyIn
);
    import sobelPkg::*;

    wordT busStart;
    magnitudeT threshold;
    logic frameActive;
    logic frameStart;
    wordT edgeWord;
    logic wordValid;
    logic fifoWrite;
    wordT readData;
    fifoCountT wordCount;
    logic readStrobe;

    configRegisters configBlock (
        .camClock(camClock),
        .reset(reset),
        .ciStart(ciStart),
        .ciN(ciN),
        .ciValueA(ciValueA),
        .ciValueB(ciValueB),
        .vsync(vsync),
        .ciResult(ciResult),
        .ciDone(ciDone),
        .busStart(busStart),
        .threshold(threshold),
        .frameActive(frameActive),
        .frameStart(frameStart)
    );

    sobelWindow producer (
        .camClock(camClock),
        .reset(reset),
        .camData(camData),
        .validCamera(validCamera),
        .hsync(hsync),
        .vsync(vsync),
        .threshold(threshold),
        .edgeWord(edgeWord),
        .wordValid(wordValid)
    );

    // Only the armed frame reaches memory
    assign fifoWrite = wordValid && frameActive;

    edgeWordFifo buffer (
        .camClock(camClock),
        .reset(reset),
        .writeStrobe(fifoWrite),
        .writeData(edgeWord),
        .readStrobe(readStrobe),
        .readData(readData),
        .wordCount(wordCount)
    );

    burstWriter consumer (
        .camClock(camClock),
        .reset(reset),
        .busStart(busStart),
        .frameStart(frameStart),
        .wordCount(wordCount),
        .readData(readData),
        .busGrant(busGrant),
        .busyIn(busyIn),
        .readStrobe(readStrobe),
        .requestBus(requestBus),
        .beginTransactionOut(beginTransactionOut),
        .addressDataOut(addressDataOut),
        .endTransactionOut(endTransactionOut),
        .byteEnablesOut(byteEnablesOut),
        .dataValidOut(dataValidOut),
        .burstSizeOut(burstSizeOut)
    );

endmodule

`default_nettype wire

// ==== rtl/sobelPkg.sv ====
`default_nettype none

package sobelPkg;

    // Pixel and line geometry
    typedef logic [7:0] pixelT;
    localparam int lineWidth = 256;
    typedef logic [8:0] columnT;
    typedef logic [9:0] rowT;

    // Sobel arithmetic, 4 * 255 fits in 12 signed bits
    typedef logic signed [11:0] gradientT;
    typedef logic [15:0] magnitudeT;

    // Edge words and bus
    typedef logic [31:0] wordT;
    localparam int wordsPerLine = lineWidth / 32;
    localparam int maxBurst = 4;
    typedef logic [2:0] burstCountT;
    localparam int addressStep = 4;

    // Edge word FIFO
    localparam int fifoDepth = 16;
    typedef logic [4:0] fifoCountT;

    // Custom instruction decode
    localparam logic [7:0] customId = 8'd0;
    typedef logic [2:0] regSelectT;
    localparam regSelectT regBusStart = 3'd1;
    localparam regSelectT regThreshold = 3'd4;
    localparam regSelectT regStatus = 3'd5;
    localparam int writeBit = 9;

    // Bus master states
    typedef enum logic [2:0] {idle, request, init, write, close} writerStateT;

endpackage

`default_nettype wire

// ==== rtl/sobelWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelWindow (
    input wire camClock,
    input wire reset,
    input wire sobelPkg::pixelT camData,
    input wire validCamera,
    input wire hsync,
    input wire vsync,
    input wire sobelPkg::magnitudeT threshold,
    output sobelPkg::wordT edgeWord,
    output logic wordValid
);
    import sobelPkg::*;

    columnT column;
    rowT row;
    // Previous row and the one before it
    pixelT lineOne [lineWidth];
    pixelT lineTwo [lineWidth];
    pixelT aboveOne;
    pixelT aboveTwo;
    // Window columns c-2 and c-1, index 0 is the top row
    pixelT windowLeft [3];
    pixelT windowMiddle [3];
    gradientT gradientX;
    gradientT gradientY;
    gradientT absX;
    gradientT absY;
    magnitudeT magnitude;
    logic edgeBit;
    logic wordEnd;
    wordT packReg;

    assign aboveOne = lineOne[column[$clog2(lineWidth)-1:0]];
    assign aboveTwo = lineTwo[column[$clog2(lineWidth)-1:0]];

    // Right column is the live pixel plus the two buffered rows
    assign gradientX = (gradientT'(aboveTwo) + (gradientT'(aboveOne) << 1) + gradientT'(camData))
        - (gradientT'(windowLeft[0]) + (gradientT'(windowLeft[1]) << 1)
        + gradientT'(windowLeft[2]));
    assign gradientY = (gradientT'(windowLeft[2]) + (gradientT'(windowMiddle[2]) << 1)
        + gradientT'(camData))
        - (gradientT'(windowLeft[0]) + (gradientT'(windowMiddle[0]) << 1)
        + gradientT'(aboveTwo));

    assign absX = gradientX[11] ? -gradientX : gradientX;
    assign absY = gradientY[11] ? -gradientY : gradientY;
    assign magnitude = magnitudeT'(absX) + magnitudeT'(absY);

    // Border pixels have no full window
    assign edgeBit = (magnitude > threshold) && (column >= columnT'(2)) && (row >= rowT'(2));
    assign wordEnd = &column[4:0];

    // Counters, row restarts on vsync only
    always_ff @(posedge camClock) begin
        if (reset || vsync) begin
            column <= '0;
            row <= '0;
        end else if (hsync) begin
            column <= '0;
            row <= row + 1'b1;
        end else if (validCamera) begin
            column <= column + 1'b1;
        end
    end

    // Line buffers and window shift together per pixel
    always_ff @(posedge camClock) begin
        if (validCamera) begin
            lineTwo[column[$clog2(lineWidth)-1:0]] <= aboveOne;
            lineOne[column[$clog2(lineWidth)-1:0]] <= camData;
            windowLeft <= windowMiddle;
            windowMiddle <= '{aboveTwo, aboveOne, camData};
        end
    end

    // First pixel of a word ends up at bit 31
    always_ff @(posedge camClock) begin
        if (reset || hsync || vsync) begin
            packReg <= '0;
        end else if (validCamera) begin
            packReg <= {packReg[30:0], edgeBit};
        end
    end

    always_ff @(posedge camClock) begin
        if (reset) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= validCamera && wordEnd;
        end
    end

    always_ff @(posedge camClock) begin
        if (validCamera && wordEnd) begin
            edgeWord <= {packReg[30:0], edgeBit};
        end
    end

    // Camera must not send a pixel on the line boundary
    assert property (@(posedge camClock) disable iff (reset) !(validCamera && hsync));

endmodule

`default_nettype wire

// ==== tests/busSlaveModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module busSlaveModel (
    input wire camClock,
    input wire reset,
    input wire requestBus,
    input wire beginTransactionOut,
    input wire dataValidOut,
    output logic busGrant,
    output logic busyIn,
    output int beginCount,
    output int acceptCount
);
    logic [31:0] randomState = 32'd47128;
    logic waiting;
    int grantDelay;

    // LCG, upper bits have the longer period
    function automatic int nextRandom();
        randomState = randomState * 32'd1103515245 + 32'd12345;
        return int'(randomState[30:16]);
    endfunction

    always @(posedge camClock) begin
        if (reset) begin
            busGrant <= 1'b0;
            busyIn <= 1'b0;
            waiting <= 1'b0;
            grantDelay <= 0;
            beginCount <= 0;
            acceptCount <= 0;
        end else begin
            // Stall about one cycle in four
            busyIn <= (nextRandom() % 4) == 0;
            // Grant is a single cycle after a random wait
            if (busGrant) begin
                busGrant <= 1'b0;
                waiting <= 1'b0;
            end else if (requestBus && !waiting) begin
                waiting <= 1'b1;
                grantDelay <= nextRandom() % 6;
            end else if (waiting && grantDelay == 0) begin
                busGrant <= 1'b1;
            end else if (waiting) begin
                grantDelay <= grantDelay - 1;
            end
            if (beginTransactionOut) begin
                beginCount <= beginCount + 1;
            end
            // Word taken when valid and not stalled
            if (dataValidOut && !busyIn) begin
                acceptCount <= acceptCount + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/cameraClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module cameraClock #(
    parameter int halfPeriod = 20
) (
    output logic camClock
);
    // 40 ns period, starts low
    initial begin
        camClock = 1'b0;
        forever begin
            #halfPeriod camClock = ~camClock;
        end
    end

endmodule

`default_nettype wire

// ==== tests/sobelAcceleratorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelAcceleratorTb;
    import sobelPkg::*;

    localparam int frameRows = 6;
    localparam int frameCount = 4;
    localparam int drainCycles = 300;
    localparam int edgeThreshold = 200;
    localparam int watchdogCycles = frameCount * frameRows * lineWidth * 4 + 2000;
    localparam int maxWords = 2 * frameRows * wordsPerLine;
    localparam wordT startA = 32'h0010_0000;
    localparam wordT startB = 32'h0020_4000;

    logic camClock;
    logic reset;
    logic hsync;
    logic vsync;
    logic validCamera;
    pixelT camData;
    logic ciStart;
    logic [7:0] ciN;
    wordT ciValueA;
    wordT ciValueB;
    wordT ciResult;
    logic ciDone;
    logic requestBus;
    logic busGrant;
    logic beginTransactionOut;
    wordT addressDataOut;
    logic endTransactionOut;
    logic [3:0] byteEnablesOut;
    logic dataValidOut;
    logic [7:0] burstSizeOut;
    logic busyIn;
    int beginCount;
    int acceptCount;
    logic acceptWord;

    // Reference image and expected bus traffic
    int image [frameRows][lineWidth];
    wordT expectedWords [maxWords];
    wordT expectedBegin [maxWords];
    int expectedCount;
    int expectedBursts;
    // Check enables driven by the stimulus
    logic busAllowed;
    logic checkpoint;
    logic resultCheck;
    wordT expectedResult;
    int errorCount;
    int testCount;
    int failedTests;
    logic [31:0] randomState = 32'd47128;

    cameraClock clockGen (.camClock(camClock));

    sobelAccelerator uut (
        .camClock(camClock),
        .reset(reset),
        .hsync(hsync),
        .vsync(vsync),
        .validCamera(validCamera),
        .camData(camData),
        .ciStart(ciStart),
        .ciN(ciN),
        .ciValueA(ciValueA),
        .ciValueB(ciValueB),
        .ciResult(ciResult),
        .ciDone(ciDone),
        .requestBus(requestBus),
        .busGrant(busGrant),
        .beginTransactionOut(beginTransactionOut),
        .addressDataOut(addressDataOut),
        .endTransactionOut(endTransactionOut),
        .byteEnablesOut(byteEnablesOut),
        .dataValidOut(dataValidOut),
        .burstSizeOut(burstSizeOut),
        .busyIn(busyIn)
    );

    busSlaveModel slave (
        .camClock(camClock),
        .reset(reset),
        .requestBus(requestBus),
        .beginTransactionOut(beginTransactionOut),
        .dataValidOut(dataValidOut),
        .busGrant(busGrant),
        .busyIn(busyIn),
        .beginCount(beginCount),
        .acceptCount(acceptCount)
    );

    assign acceptWord = dataValidOut && !busyIn;

    function automatic int nextRandom();
        randomState = randomState * 32'd1103515245 + 32'd12345;
        return int'(randomState[30:16]);
    endfunction

    // Sobel on the window centred one row up and one column left
    function automatic logic edgeAt(input int row, input int column);
        int gx;
        int gy;
        int magnitude;
        if (row < 2 || column < 2) begin
            return 1'b0;
        end
        gx = image[row-2][column] + 2 * image[row-1][column] + image[row][column]
            - image[row-2][column-2] - 2 * image[row-1][column-2] - image[row][column-2];
        gy = image[row][column-2] + 2 * image[row][column-1] + image[row][column]
            - image[row-2][column-2] - 2 * image[row-2][column-1] - image[row-2][column];
        magnitude = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        return magnitude > edgeThreshold;
    endfunction

    // Blocks of 32 columns, each flat or noisy, so both edge values occur
    task automatic buildFrame(input logic armed, input wordT baseAddress);
        int flat;
        int level;
        wordT word;
        for (int block = 0; block < wordsPerLine; block++) begin
            flat = nextRandom() % 2;
            level = nextRandom() % 256;
            for (int r = 0; r < frameRows; r++) begin
                for (int c = block * 32; c < block * 32 + 32; c++) begin
                    image[r][c] = (flat == 1) ? level : nextRandom() % 256;
                end
            end
        end
        if (armed) begin
            for (int b = 0; b < frameRows * wordsPerLine / maxBurst; b++) begin
                expectedBegin[expectedBursts] = baseAddress + wordT'(b * maxBurst * addressStep);
                expectedBursts++;
            end
            // First pixel of each word lands in bit 31
            for (int r = 0; r < frameRows; r++) begin
                for (int k = 0; k < wordsPerLine; k++) begin
                    word = '0;
                    for (int j = 0; j < 32; j++) begin
                        word[31-j] = edgeAt(r, k * 32 + j);
                    end
                    expectedWords[expectedCount] = word;
                    expectedCount++;
                end
            end
        end
    endtask

    task automatic idleCycles(input int count);
        repeat (count) @(posedge camClock);
    endtask

    // One pixel then one empty cycle
    task automatic sendPixel(input pixelT value);
        @(posedge camClock);
        camData <= value;
        validCamera <= 1'b1;
        @(posedge camClock);
        validCamera <= 1'b0;
    endtask

    task automatic pulseHsync();
        @(posedge camClock);
        hsync <= 1'b1;
        @(posedge camClock);
        hsync <= 1'b0;
    endtask

    task automatic ciAccess(input logic [7:0] number, input regSelectT select,
            input logic write, input wordT value, input wordT expected, input logic check);
        @(posedge camClock);
        ciStart <= 1'b1;
        ciN <= number;
        ciValueA <= wordT'({select, write, 9'd0});
        ciValueB <= value;
        resultCheck <= check;
        expectedResult <= expected;
        @(posedge camClock);
        ciStart <= 1'b0;
        ciValueA <= '0;
        resultCheck <= 1'b0;
    endtask

    task automatic sendFrame(input wordT statusExpected);
        @(posedge camClock);
        vsync <= 1'b1;
        @(posedge camClock);
        vsync <= 1'b0;
        idleCycles(2);
        // Status once the frame boundary has passed
        ciAccess(customId, regStatus, 1'b0, '0, statusExpected, 1'b1);
        for (int r = 0; r < frameRows; r++) begin
            for (int c = 0; c < lineWidth; c++) begin
                sendPixel(pixelT'(image[r][c]));
            end
            pulseHsync();
            idleCycles(2);
        end
        // Let the FIFO empty before the next vsync
        idleCycles(drainCycles);
    endtask

    task automatic pulseCheckpoint();
        @(posedge camClock);
        checkpoint <= 1'b1;
        @(posedge camClock);
        checkpoint <= 1'b0;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s: pass", name);
        end else begin
            failedTests++;
            $display("test %s: fail, %0d check errors", name, errorCount - errorsBefore);
        end
    endtask

    // Checks sample on the falling edge, away from all updates
    assert property (@(negedge camClock) disable iff (reset)
        ciDone == (ciStart && ciN == customId))
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: ciDone got %b expected %b", $time, ciDone,
            ciStart && ciN == customId);
    end

    assert property (@(negedge camClock) disable iff (reset) !ciDone |-> ciResult == '0)
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: ciResult got %h expected %h", $time, ciResult, 32'd0);
    end

    assert property (@(negedge camClock) disable iff (reset)
        resultCheck |-> ciResult == expectedResult)
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: ciResult got %h expected %h", $time, ciResult,
            expectedResult);
    end

    assert property (@(negedge camClock) disable iff (reset) !busAllowed |-> !requestBus)
    else begin
        errorCount = errorCount + 1;
        $display("error at %0t: requestBus went high outside an armed frame", $time);
    end

    assert property (@(negedge camClock) disable iff (reset)
        beginTransactionOut |-> addressDataOut == expectedBegin[beginCount])
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: addressDataOut got %h expected %h", $time,
            addressDataOut, expectedBegin[beginCount]);
    end

    assert property (@(negedge camClock) disable iff (reset)
        beginTransactionOut |-> burstSizeOut == 8'(maxBurst - 1))
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: burstSizeOut got %0d expected %0d", $time,
            burstSizeOut, maxBurst - 1);
    end

    assert property (@(negedge camClock) disable iff (reset)
        beginTransactionOut |-> byteEnablesOut == 4'hf)
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: byteEnablesOut got %h expected %h", $time,
            byteEnablesOut, 4'hf);
    end

    assert property (@(negedge camClock) disable iff (reset)
        acceptWord |-> acceptCount < expectedCount)
    else begin
        errorCount = errorCount + 1;
        $display("error at %0t: the bus accepted more words than the model produced", $time);
    end

    assert property (@(negedge camClock) disable iff (reset)
        acceptWord |-> addressDataOut == expectedWords[acceptCount])
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: addressDataOut got %h expected %h", $time,
            addressDataOut, expectedWords[acceptCount]);
    end

    // End pulse one cycle after the fourth word of each burst is taken
    assert property (@(negedge camClock) disable iff (reset)
        endTransactionOut == $past(acceptWord && (acceptCount % maxBurst == maxBurst - 1)))
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: endTransactionOut got %b expected %b", $time,
            endTransactionOut, !endTransactionOut);
    end

    // Stalled word must stay on the bus
    assert property (@(negedge camClock) disable iff (reset)
        (dataValidOut && busyIn) |=> (dataValidOut && $stable(addressDataOut)))
    else begin
        errorCount = errorCount + 1;
        $display("error at %0t: a word changed or vanished while busyIn was high", $time);
    end

    assert property (@(negedge camClock) disable iff (reset)
        checkpoint |-> acceptCount == expectedCount)
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: acceptCount got %0d expected %0d", $time,
            acceptCount, expectedCount);
    end

    assert property (@(negedge camClock) disable iff (reset)
        checkpoint |-> beginCount == expectedBursts)
    else begin
        errorCount = errorCount + 1;
        $display("mismatch at %0t: beginCount got %0d expected %0d", $time,
            beginCount, expectedBursts);
    end

    initial begin
        int errorsBefore;
        reset = 1'b1;
        hsync = 1'b0;
        vsync = 1'b0;
        validCamera = 1'b0;
        camData = '0;
        ciStart = 1'b0;
        ciN = '0;
        ciValueA = '0;
        ciValueB = '0;
        busAllowed = 1'b0;
        checkpoint = 1'b0;
        resultCheck = 1'b0;
        expectedResult = '0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        expectedCount = 0;
        expectedBursts = 0;
        repeat (5) @(posedge camClock);
        reset <= 1'b0;

        // Register writes read back, writes return zero
        errorsBefore = errorCount;
        ciAccess(customId, regBusStart, 1'b1, startA, '0, 1'b1);
        ciAccess(customId, regBusStart, 1'b0, '0, startA, 1'b1);
        ciAccess(customId, regThreshold, 1'b1, 32'h5a5a_0000 | edgeThreshold, '0, 1'b1);
        ciAccess(customId, regThreshold, 1'b0, '0, wordT'(edgeThreshold), 1'b1);
        ciAccess(customId, 3'd3, 1'b0, '0, '0, 1'b1);
        ciAccess(customId, 3'd7, 1'b1, 32'hffff, '0, 1'b1);
        ciAccess(8'h2a, regBusStart, 1'b0, '0, '0, 1'b0);
        ciAccess(customId, regStatus, 1'b0, '0, '0, 1'b1);
        finishTest("register access", errorsBefore);

        // No start command, bus stays quiet
        errorsBefore = errorCount;
        buildFrame(1'b0, '0);
        sendFrame('0);
        finishTest("idle frame without start", errorsBefore);

        // Armed frame under random busy
        errorsBefore = errorCount;
        ciAccess(customId, regStatus, 1'b1, '0, '0, 1'b1);
        ciAccess(customId, regStatus, 1'b0, '0, 32'd1, 1'b1);
        buildFrame(1'b1, startA);
        @(posedge camClock);
        busAllowed <= 1'b1;
        sendFrame(32'd1);
        pulseCheckpoint();
        finishTest("edge map and burst addressing", errorsBefore);

        // Done status, frame after the armed one writes nothing
        errorsBefore = errorCount;
        @(posedge camClock);
        busAllowed <= 1'b0;
        buildFrame(1'b0, '0);
        sendFrame(32'd2);
        finishTest("one-shot status", errorsBefore);

        // New start address takes effect at the next armed frame
        errorsBefore = errorCount;
        ciAccess(customId, regBusStart, 1'b1, startB, '0, 1'b1);
        ciAccess(customId, regStatus, 1'b1, '0, '0, 1'b1);
        ciAccess(customId, regStatus, 1'b0, '0, 32'd1, 1'b1);
        buildFrame(1'b1, startB);
        @(posedge camClock);
        busAllowed <= 1'b1;
        sendFrame(32'd1);
        pulseCheckpoint();
        finishTest("address reload", errorsBefore);

        $display("tests run %0d, tests failed %0d, check errors %0d", testCount,
            failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Four cycles per pixel over all frames, plus slack for register access
    initial begin
        repeat (watchdogCycles) @(posedge camClock);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
